// ==== include/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// architectural register file.
`define RENAME_NUM_REGS  32
`define RENAME_REG_BITS  5

// reorder buffer, tag width must cover the depth.
`define RENAME_ROB_DEPTH 8
`define RENAME_TAG_BITS  3

`define RENAME_DATA_BITS 32

`endif

// ==== logic/rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_e;

    typedef struct packed {
        logic [`RENAME_REG_BITS-1:0] rs1;
        logic [`RENAME_REG_BITS-1:0] rs2;
        logic [`RENAME_REG_BITS-1:0] rd;
        op_e                         op;
        logic [31:0]                 pc;
        logic [31:0]                 imm;
    } issue_t;

    typedef struct packed {
        logic                         busy;
        logic [`RENAME_TAG_BITS-1:0]  tag;   // valid only while busy.
        logic [`RENAME_DATA_BITS-1:0] value; // zero while busy.
    } operand_t;

    typedef struct packed {
        operand_t                    src1;
        operand_t                    src2;
        logic [`RENAME_REG_BITS-1:0] rd;
        op_e                         op;
        logic [31:0]                 pc;
        logic [31:0]                 imm;
        logic [`RENAME_TAG_BITS-1:0] tag;
    } dispatch_t;

    typedef struct packed {
        logic [`RENAME_TAG_BITS-1:0]  tag;
        logic [`RENAME_DATA_BITS-1:0] value;
    } complete_t;

    typedef struct packed {
        logic [`RENAME_TAG_BITS-1:0]  tag;
        logic [`RENAME_REG_BITS-1:0]  rd;
        logic                         writes_rd;
        logic [`RENAME_DATA_BITS-1:0] value;
    } commit_t;

    typedef struct packed {
        logic                         busy;
        logic                         done;
        logic [`RENAME_REG_BITS-1:0]  rd;
        logic                         writes_rd;
        logic [`RENAME_DATA_BITS-1:0] value;
    } rob_slot_t;

    // stores and branches hold an entry but leave rd alone.
    function automatic logic op_writes_rd(input op_e op);
        return (op == OP_ALU) || (op == OP_LOAD);
    endfunction

endpackage

// ==== logic/rename_regfile.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        issue_valid,
    input  rename_pkg::issue_t          issue,
    input  logic [`RENAME_TAG_BITS-1:0] alloc_tag,
    input  logic                        commit_valid,
    input  rename_pkg::commit_t         commit,
    output logic                        dispatch_valid,
    output rename_pkg::dispatch_t       dispatch
);

    logic [`RENAME_DATA_BITS-1:0] reg_value [`RENAME_NUM_REGS];
    logic                         reg_busy  [`RENAME_NUM_REGS];
    logic [`RENAME_TAG_BITS-1:0]  reg_tag   [`RENAME_NUM_REGS];

    logic commit_wr;
    logic rename_wr;

    assign commit_wr = commit_valid && commit.writes_rd && (commit.rd != '0);
    assign rename_wr = issue_valid && !flush && (issue.rd != '0)
                       && rename_pkg::op_writes_rd(issue.op);

    // state as it stands once this edge's commit has landed.
    function automatic rename_pkg::operand_t lookup(input logic [`RENAME_REG_BITS-1:0] rs);
        rename_pkg::operand_t opnd;
        logic                 hit;
        hit = commit_wr && (commit.rd == rs);
        opnd.busy = reg_busy[rs] && !(hit && (reg_tag[rs] == commit.tag));
        opnd.tag  = opnd.busy ? reg_tag[rs] : '0;
        if (opnd.busy) begin
            opnd.value = '0;
        end else if (hit) begin
            opnd.value = commit.value;
        end else begin
            opnd.value = reg_value[rs];
        end
        if (rs == '0) begin
            opnd = '0; // x0 is hardwired.
        end
        return opnd;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RENAME_NUM_REGS; i++) begin
                reg_value[i] <= '0;
                reg_busy[i]  <= 1'b0;
                reg_tag[i]   <= '0;
            end
        end else begin
            if (commit_wr) begin
                reg_value[commit.rd] <= commit.value;
                if (reg_tag[commit.rd] == commit.tag) begin
                    reg_busy[commit.rd] <= 1'b0; // newer writer keeps its rename.
                end
            end
            if (flush) begin
                for (int i = 0; i < `RENAME_NUM_REGS; i++) begin
                    reg_busy[i] <= 1'b0;
                    reg_tag[i]  <= '0;
                end
            end else if (rename_wr) begin
                reg_busy[issue.rd] <= 1'b1;
                reg_tag[issue.rd]  <= alloc_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            dispatch.src1 <= lookup(issue.rs1);
            dispatch.src2 <= lookup(issue.rs2);
            dispatch.rd   <= issue.rd;
            dispatch.op   <= issue.op;
            dispatch.pc   <= issue.pc;
            dispatch.imm  <= issue.imm;
            dispatch.tag  <= alloc_tag;
        end
    end

endmodule

// ==== logic/rob_alloc.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rob_alloc (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         issue_valid,
    input  rename_pkg::issue_t           issue,
    input  logic                         retire,
    output logic [`RENAME_TAG_BITS-1:0]  alloc_tag,
    output logic [`RENAME_ROB_DEPTH-1:0] alloc_we,
    output rename_pkg::issue_t           alloc_issue,
    output logic                         full
);

    localparam logic [`RENAME_TAG_BITS-1:0] LAST = `RENAME_TAG_BITS'(`RENAME_ROB_DEPTH - 1);

    logic [`RENAME_TAG_BITS-1:0] tail;
    logic [`RENAME_TAG_BITS:0]   count;
    logic                        alloc;

    assign alloc       = issue_valid && !flush;
    assign alloc_tag   = tail;
    assign alloc_issue = issue; // fields shared by every entry.
    assign full        = (count == (`RENAME_TAG_BITS+1)'(`RENAME_ROB_DEPTH));

    always_comb begin
        alloc_we = '0;
        if (alloc) begin
            alloc_we[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= (tail == LAST) ? '0 : tail + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

// ==== logic/rob_entry.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rob_entry #(
    parameter int INDEX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  alloc_we,
    input  rename_pkg::issue_t    issue,
    input  logic                  complete_valid,
    input  rename_pkg::complete_t complete,
    input  logic                  retire,
    output rename_pkg::rob_slot_t slot
);

    localparam logic [`RENAME_TAG_BITS-1:0] TAG = `RENAME_TAG_BITS'(INDEX);

    logic hit;

    assign hit = complete_valid && (complete.tag == TAG);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            slot.busy <= 1'b0;
            slot.done <= 1'b0;
        end else if (alloc_we) begin
            slot.busy <= 1'b1;
            slot.done <= 1'b0;
        end else if (retire) begin
            slot.busy <= 1'b0;
            slot.done <= 1'b0;
        end else if (hit) begin
            slot.done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            slot.rd        <= issue.rd;
            slot.writes_rd <= rename_pkg::op_writes_rd(issue.op);
        end
        if (hit) begin
            slot.value <= complete.value;
        end
    end

endmodule

// ==== logic/rob_commit.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rob_commit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  rename_pkg::rob_slot_t        slots [`RENAME_ROB_DEPTH],
    output logic [`RENAME_ROB_DEPTH-1:0] retire_we,
    output logic                         retire,
    output logic                         commit_valid,
    output rename_pkg::commit_t          commit
);

    localparam logic [`RENAME_TAG_BITS-1:0] LAST = `RENAME_TAG_BITS'(`RENAME_ROB_DEPTH - 1);

    logic [`RENAME_TAG_BITS-1:0] head;
    rename_pkg::rob_slot_t       head_slot;

    assign head_slot = slots[head];
    assign retire    = head_slot.busy && head_slot.done && !flush; // oldest only.

    always_comb begin
        retire_we = '0;
        if (retire) begin
            retire_we[head] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head         <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (retire) begin
                head <= (head == LAST) ? '0 : head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit.tag       <= head;
            commit.rd        <= head_slot.rd;
            commit.writes_rd <= head_slot.writes_rd;
            commit.value     <= head_slot.value;
        end
    end

endmodule

// ==== logic/rename_core.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  rename_pkg::issue_t    issue,
    input  logic                  complete_valid,
    input  rename_pkg::complete_t complete,
    output logic                  dispatch_valid,
    output rename_pkg::dispatch_t dispatch,
    output logic                  commit_valid,
    output rename_pkg::commit_t   commit,
    output logic                  full
);

    logic [`RENAME_TAG_BITS-1:0]  alloc_tag;
    logic [`RENAME_ROB_DEPTH-1:0] alloc_we;
    logic [`RENAME_ROB_DEPTH-1:0] retire_we;
    logic                         retire;
    rename_pkg::issue_t           alloc_issue;
    rename_pkg::rob_slot_t        slots [`RENAME_ROB_DEPTH];

    rename_regfile regfile_i (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .alloc_tag      (alloc_tag),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch)
    );

    rob_alloc alloc_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .retire      (retire),
        .alloc_tag   (alloc_tag),
        .alloc_we    (alloc_we),
        .alloc_issue (alloc_issue),
        .full        (full)
    );

    for (genvar i = 0; i < `RENAME_ROB_DEPTH; i++) begin : g_entry
        rob_entry #(
            .INDEX (i)
        ) entry_i (
            .clk            (clk),
            .rst            (rst),
            .flush          (flush),
            .alloc_we       (alloc_we[i]),
            .issue          (alloc_issue),
            .complete_valid (complete_valid),
            .complete       (complete),
            .retire         (retire_we[i]),
            .slot           (slots[i])
        );
    end

    rob_commit commit_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .slots        (slots),
        .retire_we    (retire_we),
        .retire       (retire),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// ==== verification/rename_clock.sv ====
`timescale 1ns/1ps

module rename_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk); // released between edges.
        rst = 1'b0;
    end

endmodule

// ==== verification/rename_properties.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input logic                  issue_valid,
    input logic                  complete_valid,
    input rename_pkg::complete_t complete,
    input logic                  dispatch_valid,
    input logic                  commit_valid,
    input rename_pkg::commit_t   commit,
    input logic                  full,
    input rename_pkg::rob_slot_t slots [`RENAME_ROB_DEPTH]
);

    logic [`RENAME_TAG_BITS-1:0] prev_tag;
    logic                        have_prev;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            have_prev <= 1'b0;
            prev_tag  <= '0;
        end else if (commit_valid) begin
            have_prev <= 1'b1;
            prev_tag  <= commit.tag;
        end
    end

    issue_not_full: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !full)
        else $error("issue while the ROB is full");

    complete_busy: assert property (@(posedge clk) disable iff (rst)
        (complete_valid && !flush) |-> slots[complete.tag].busy)
        else $error("completion names an entry that is not busy");

    flush_no_dispatch: assert property (@(posedge clk) disable iff (rst)
        flush |=> !dispatch_valid)
        else $error("dispatch strobe right after a flush");

    commit_in_order: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && have_prev) |-> (commit.tag == prev_tag + 1'b1))
        else $error("commit tags out of order");

endmodule

bind rename_core rename_properties props_i (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .issue_valid    (issue_valid),
    .complete_valid (complete_valid),
    .complete       (complete),
    .dispatch_valid (dispatch_valid),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .full           (full),
    .slots          (slots)
);

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_tb;

    localparam int DEPTH       = `RENAME_ROB_DEPTH;
    localparam int NREGS       = `RENAME_NUM_REGS;
    localparam int NUM_RANDOM  = 300;
    localparam int NUM_ISSUES  = 34 + 5 + 16 + NUM_RANDOM;
    localparam int CYCLE_LIMIT = NUM_ISSUES * (DEPTH + 4) + 100;

    logic clk;
    logic rst;
    logic flush;
    logic issue_valid;
    logic complete_valid;
    logic dispatch_valid;
    logic commit_valid;
    logic full;
    rename_pkg::issue_t    issue;
    rename_pkg::complete_t complete;
    rename_pkg::dispatch_t dispatch;
    rename_pkg::commit_t   commit;

    // reference state.
    logic [31:0] m_val  [NREGS];
    logic        m_busy [NREGS];
    logic [2:0]  m_tag  [NREGS];
    logic        e_busy [DEPTH];
    logic        e_done [DEPTH];
    logic [4:0]  e_rd   [DEPTH];
    logic        e_wr   [DEPTH];
    logic [31:0] e_val  [DEPTH];
    int head;
    int tail;
    int count;
    int cycles;
    bit live;
    bit exp_dv;
    bit exp_cv;
    bit exp_full;
    rename_pkg::dispatch_t exp_d;
    rename_pkg::commit_t   exp_c;
    event model_done;

    rename_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) clock_i (.clk(clk), .rst(rst));

    rename_core dut_i (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .complete_valid (complete_valid),
        .complete       (complete),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .full           (full)
    );

    function automatic bit writes_dest(input rename_pkg::op_e op);
        return (op == rename_pkg::OP_ALU) || (op == rename_pkg::OP_LOAD);
    endfunction

    // operand as seen after this edge's commit, before the new rename.
    function automatic rename_pkg::operand_t ref_lookup(input logic [4:0] rs);
        rename_pkg::operand_t o;
        o = '0;
        if (rs != 5'd0) begin
            o.busy  = m_busy[rs];
            o.tag   = m_busy[rs] ? m_tag[rs] : 3'd0;
            o.value = m_busy[rs] ? 32'd0 : m_val[rs];
        end
        return o;
    endfunction

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_dispatch(input rename_pkg::dispatch_t got,
                                  input rename_pkg::dispatch_t want);
        if (got !== want) begin
            $display("** Error: dispatch got %h expected %h", got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_commit(input rename_pkg::commit_t got, input rename_pkg::commit_t want);
        if (got !== want) begin
            $display("** Error: commit got %h expected %h", got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_full(input logic got, input logic want);
        if (got !== want) begin
            $display("** Error: full got %h expected %h", got, want);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin : model_step
        bit ret;
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                m_val[i]  = '0;
                m_busy[i] = 1'b0;
                m_tag[i]  = '0;
            end
            for (int i = 0; i < DEPTH; i++) begin
                e_busy[i] = 1'b0;
                e_done[i] = 1'b0;
            end
            head = 0;
            tail = 0;
            count = 0;
            exp_dv = 0;
            exp_cv = 0;
            exp_full = 0;
        end else begin
            live = 1;
            if (exp_cv && exp_c.writes_rd && exp_c.rd != 5'd0) begin
                m_val[exp_c.rd] = exp_c.value;
                if (m_tag[exp_c.rd] == exp_c.tag) m_busy[exp_c.rd] = 1'b0;
            end
            ret = e_busy[head] && e_done[head] && !flush;
            exp_cv = ret;
            if (ret) begin
                exp_c.tag       = 3'(head);
                exp_c.rd        = e_rd[head];
                exp_c.writes_rd = e_wr[head];
                exp_c.value     = e_val[head];
            end
            exp_dv = issue_valid && !flush;
            if (exp_dv) begin
                exp_d.src1 = ref_lookup(issue.rs1);
                exp_d.src2 = ref_lookup(issue.rs2);
                exp_d.rd   = issue.rd;
                exp_d.op   = issue.op;
                exp_d.pc   = issue.pc;
                exp_d.imm  = issue.imm;
                exp_d.tag  = 3'(tail);
            end
            if (flush) begin
                for (int i = 0; i < NREGS; i++) m_busy[i] = 1'b0;
                for (int i = 0; i < NREGS; i++) m_tag[i] = '0;
                for (int i = 0; i < DEPTH; i++) e_busy[i] = 1'b0;
                head = 0;
                tail = 0;
                count = 0;
            end else begin
                if (ret) begin
                    e_busy[head] = 1'b0;
                    head = (head + 1) % DEPTH;
                    count--;
                end
                if (complete_valid) begin
                    e_done[complete.tag] = 1'b1;
                    e_val[complete.tag]  = complete.value;
                end
                if (issue_valid) begin
                    e_busy[tail] = 1'b1;
                    e_done[tail] = 1'b0;
                    e_rd[tail]   = issue.rd;
                    e_wr[tail]   = writes_dest(issue.op);
                    if (writes_dest(issue.op) && issue.rd != 5'd0) begin
                        m_busy[issue.rd] = 1'b1;
                        m_tag[issue.rd]  = 3'(tail);
                    end
                    tail = (tail + 1) % DEPTH;
                    count++;
                end
            end
            exp_full = (count == DEPTH);
        end
        -> model_done;
    end

    always @(negedge clk) begin
        if (live) begin
            check_full(full, exp_full);
            if (dispatch_valid !== exp_dv) begin
                $display("dispatch strobe was %b where %b was expected", dispatch_valid, exp_dv);
                stop_with_failure();
            end else if (exp_dv) begin
                check_dispatch(dispatch, exp_d);
            end
            if (commit_valid !== exp_cv) begin
                $display("commit strobe was %b where %b was expected", commit_valid, exp_cv);
                stop_with_failure();
            end else if (exp_cv) begin
                check_commit(commit, exp_c);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    task automatic drive(input bit iv, input rename_pkg::issue_t is, input bit cv,
                         input rename_pkg::complete_t c, input bit fl);
        @(negedge clk);
        issue_valid    = iv;
        issue          = is;
        complete_valid = cv;
        complete       = c;
        flush          = fl;
        @(model_done); // model now holds the state after these inputs.
    endtask

    function automatic rename_pkg::issue_t make_issue(input rename_pkg::op_e op,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
        rename_pkg::issue_t is;
        is.rs1 = rs1;
        is.rs2 = rs2;
        is.rd  = rd;
        is.op  = op;
        is.pc  = $urandom;
        is.imm = $urandom;
        return is;
    endfunction

    task automatic issue_op(input rename_pkg::op_e op, input int rs1, input int rs2, input int rd);
        drive(1, make_issue(op, 5'(rs1), 5'(rs2), 5'(rd)), 0, '0, 0);
    endtask

    task automatic complete_tag(input int t);
        rename_pkg::complete_t c;
        c.tag   = 3'(t);
        c.value = $urandom;
        drive(0, '0, 1, c, 0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive(0, '0, 0, '0, 0);
    endtask

    // random entry that is busy and still waiting for its result.
    function automatic int pick_pending();
        int q[$];
        for (int i = 0; i < DEPTH; i++) begin
            if (e_busy[i] && !e_done[i]) q.push_back(i);
        end
        if (q.size() == 0) return -1;
        return q[$urandom_range(0, q.size() - 1)];
    endfunction

    task automatic drain();
        int t;
        while (count > 0) begin
            t = pick_pending();
            if (t >= 0) complete_tag(t);
            else idle(1);
        end
        idle(3);
    endtask

    task automatic random_traffic();
        rename_pkg::complete_t c;
        rename_pkg::op_e       op;
        int n;
        int t;
        bit iv;
        n = 0;
        while (n < NUM_RANDOM) begin
            iv = (count < DEPTH) && ($urandom_range(0, 1) == 1);
            t = pick_pending();
            c.tag   = 3'(t);
            c.value = $urandom;
            op = rename_pkg::op_e'($urandom_range(0, 3));
            drive(iv, make_issue(op, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                  5'($urandom_range(0, 7))), (t >= 0) && ($urandom_range(0, 2) != 0), c, 0);
            if (iv) n++;
        end
    endtask

    initial begin
        int ta;
        void'($urandom(32'ha26f_0e67));
        flush = 0;
        issue_valid = 0;
        issue = '0;
        complete_valid = 0;
        complete = '0;
        cycles = 0;
        live = 0;
        wait (!rst);
        // reset values, and stores never rename.
        for (int r = 0; r < NREGS; r++) begin
            issue_op(rename_pkg::OP_STORE, r, NREGS - 1 - r, r);
            if (count >= DEPTH - 1) drain();
        end
        drain();
        issue_op(rename_pkg::OP_ALU, 0, 0, 0);
        drain();
        issue_op(rename_pkg::OP_BRANCH, 0, 0, 0);
        drain();
        // two writers of x5.
        ta = tail;
        issue_op(rename_pkg::OP_ALU, 1, 2, 5);
        issue_op(rename_pkg::OP_STORE, 5, 0, 0);
        issue_op(rename_pkg::OP_LOAD, 3, 5, 5);
        complete_tag(ta);
        idle(3);
        issue_op(rename_pkg::OP_STORE, 5, 5, 0);
        drain();
        issue_op(rename_pkg::OP_STORE, 5, 0, 0);
        drain();
        // flush a full ROB with work in flight.
        for (int r = 1; r <= DEPTH; r++) issue_op(rename_pkg::OP_ALU, r + 8, r, r);
        complete_tag((head + 1) % DEPTH);
        complete_tag((head + 3) % DEPTH);
        drive(0, '0, 0, '0, 1);
        issue_op(rename_pkg::OP_ALU, 1, 2, 6);
        drive(1, make_issue(rename_pkg::OP_ALU, 3, 6, 7), 0, '0, 1);
        idle(3);
        for (int r = 0; r < 6; r++) issue_op(rename_pkg::OP_STORE, r, r + 1, r);
        drain();
        random_traffic();
        drain();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== rename_core.f ====
+incdir+include
logic/rename_pkg.sv
logic/rename_regfile.sv
logic/rob_alloc.sv
logic/rob_entry.sv
logic/rob_commit.sv
logic/rename_core.sv
verification/rename_clock.sv
verification/rename_properties.sv
verification/rename_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rename_core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rename_core.f --top-module rename_tb \
    -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/rename_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
